/* list.f */
+incdir+design
+incdir+test
design/pad_pkg.sv
design/pad_decode.sv
design/mouse_packet.sv
design/tap_sequencer.sv
design/pad_port_top.sv
test/tb_pad_port_top.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the controller port testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f list.f --top-module tb_pad_port_top \
	--Mdir obj_dir -o sim_pad_port
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/sim_pad_port > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q '\*\*\* PASSED \*\*\*' "$LOG"; then
	echo "result: pass"
	exit 0
else
	echo "result: fail"
	exit 1
fi

/* test/tb_pad_checks.svh */
/*
 * Testbench checks
 * Error counters and the typed compare for the console nibble
 */

`ifndef TB_PAD_CHECKS_SVH
`define TB_PAD_CHECKS_SVH

int err_count = 0;      // Wrong values seen
int timeout_count = 0;  // Waits that ran out

// Compare one console read against its expected value
task automatic check_nibble(
	input pad_pkg::nibble_t exp,
	input pad_pkg::nibble_t act,
	input int               row
);
	if (act !== exp) begin
		err_count++;
		$display("error joy_in row %0d: expected %h, got %h", row, exp, act);
	end
endtask

// A wait that gave up
task automatic note_timeout(input string what);
	timeout_count++;
	$display("timeout: %s did not finish in time", what);
endtask

`endif

/* test/tb_pad_port_top.sv */
/*
 * Controller port testbench
 * Table driven reads of the console nibble over pads, multitap,
 * six-button pads and the mouse
 */

`default_nettype none

`include "pad_params.svh"

module tb_pad_port_top;

	localparam int SETTLE_CYCLES = 4;

	typedef struct packed {
		pad_pkg::pad_ctrl_t                       ctrl;
		pad_pkg::pad_cfg_t                        cfg;
		pad_pkg::host_pad_t [`PAD_PORT_COUNT-1:0] pads;
		pad_pkg::mouse_report_t                   mouse;
		pad_pkg::nibble_t                         exp;
	} row_t;

	logic                   clk_sys;
	logic                   rst;
	pad_pkg::pad_ctrl_t     ctrl;
	pad_pkg::pad_cfg_t      cfg;
	pad_pkg::host_pad_t     host_pads [`PAD_PORT_COUNT];
	pad_pkg::mouse_report_t mouse;
	pad_pkg::nibble_t       joy_in;

	int seed = 32'hd27ec1fa;
	row_t table_q [$];
	pad_pkg::pad_cfg_t cur_cfg;
	pad_pkg::host_pad_t [`PAD_PORT_COUNT-1:0] cur_pads;
	pad_pkg::mouse_report_t cur_mouse;
	int clr_rises = 0;  // Mouse nibble position follows these

	`include "tb_pad_checks.svh"

	pad_port_top i_pad_port_top (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.ctrl      (ctrl),
		.cfg       (cfg),
		.host_pads (host_pads),
		.mouse     (mouse),
		.joy_in    (joy_in)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// Hard stop if the clock or a loop stalls
	initial begin
		#100000;
		$display("timeout: simulation ran past its time limit");
		$display("*** FAILED ***");
		$finish;
	end

	// ==============================
	// Expected values
	// ==============================

	// Active-low console nibble from the host bit order
	function automatic pad_pkg::nibble_t pad_nibble(input pad_pkg::host_pad_t h, input int idx);
		case (idx)
			0: pad_nibble = ~h[7:4];                     // Run, select, II, I
			1: pad_nibble = ~{h[1], h[2], h[0], h[3]};   // Left, down, right, up
			2: pad_nibble = ~h[11:8];                    // VI..III
			default: pad_nibble = 4'h0;
		endcase
	endfunction

	function automatic pad_pkg::nibble_t mouse_low_nibble(input pad_pkg::host_pad_t h,
			input logic l, input logic r);
		pad_pkg::nibble_t n0;

		n0 = pad_nibble(h, 0);
		mouse_low_nibble = {n0[3:2], ~l, ~r};
	endfunction

	function automatic pad_pkg::host_pad_t port0_pad();
		port0_pad = cur_cfg.swap ? cur_pads[1] : cur_pads[0];
	endfunction

	// ==============================
	// Table building
	// ==============================

	task automatic randomize_pads();
		for (int i = 0; i < `PAD_PORT_COUNT; i++)
			cur_pads[i] = pad_pkg::host_pad_t'($random(seed));
	endtask

	task automatic push_row(input logic clr, input logic sel, input pad_pkg::nibble_t exp);
		row_t r;

		r.ctrl.clr = clr;
		r.ctrl.sel = sel;
		r.cfg      = cur_cfg;
		r.pads     = cur_pads;
		r.mouse    = cur_mouse;
		r.exp      = exp;
		table_q.push_back(r);
		cur_mouse.strobe = 1'b0;  // Report goes out once
	endtask

	task automatic clr_pulse();
		push_row(1'b1, 1'b0, 4'h0);
		clr_rises++;
	endtask

	task automatic build_table();
		pad_pkg::mouse_delta_t ax, ay, bx;

		cur_cfg   = '0;
		cur_mouse = '0;

		// Plain pad on port 0, sel toggles leave the port alone
		randomize_pads();
		clr_pulse();
		push_row(1'b0, 1'b0, pad_nibble(port0_pad(), 0));
		push_row(1'b0, 1'b1, pad_nibble(port0_pad(), 1));
		push_row(1'b0, 1'b0, pad_nibble(port0_pad(), 0));
		push_row(1'b0, 1'b1, pad_nibble(port0_pad(), 1));

		// Swapped host ports
		randomize_pads();
		cur_cfg.swap = 1'b1;
		clr_pulse();
		push_row(1'b0, 1'b0, pad_nibble(port0_pad(), 0));
		push_row(1'b0, 1'b1, pad_nibble(port0_pad(), 1));

		// Multitap walk through all eight port numbers
		randomize_pads();
		cur_cfg = '0;
		cur_cfg.turbotap = 1'b1;
		clr_pulse();
		push_row(1'b0, 1'b0, pad_nibble(cur_pads[0], 0));
		for (int p = 1; p < 8; p++) begin
			push_row(1'b0, 1'b1, p < `PAD_PORT_COUNT ? pad_nibble(cur_pads[p], 1) : 4'hF);
			push_row(1'b0, 1'b0, p < `PAD_PORT_COUNT ? pad_nibble(cur_pads[p], 0) : 4'hF);
		end
		push_row(1'b0, 1'b1, pad_nibble(cur_pads[0], 1));  // Wrapped to port 0

		// Six-button halves
		randomize_pads();
		cur_cfg = '0;
		cur_cfg.buttons6 = 1'b1;
		clr_pulse();
		push_row(1'b0, 1'b0, pad_nibble(cur_pads[0], 2));
		push_row(1'b0, 1'b1, pad_nibble(cur_pads[0], 3));
		clr_pulse();
		push_row(1'b0, 1'b0, pad_nibble(cur_pads[0], 0));
		push_row(1'b0, 1'b1, pad_nibble(cur_pads[0], 1));
		clr_pulse();
		push_row(1'b0, 1'b0, pad_nibble(cur_pads[0], 2));
		cur_cfg.buttons6 = 1'b0;
		clr_pulse();
		push_row(1'b0, 1'b0, pad_nibble(cur_pads[0], 0));
		clr_pulse();
		push_row(1'b0, 1'b0, pad_nibble(cur_pads[0], 0));
		push_row(1'b0, 1'b1, pad_nibble(cur_pads[0], 1));

		// ==============================
		// Mouse on port 0
		// ==============================
		randomize_pads();
		cur_cfg = '0;
		cur_cfg.mouse_en = 1'b1;
		cur_mouse.lbtn = 1'b1;
		clr_pulse();
		while (clr_rises % 4 != 0) begin
			push_row(1'b0, 1'b0, mouse_low_nibble(port0_pad(), 1'b1, 1'b0));
			clr_pulse();  // Last nibble of a packet
		end
		push_row(1'b0, 1'b0, mouse_low_nibble(port0_pad(), 1'b1, 1'b0));
		push_row(1'b0, 1'b1, 4'h0);

		cur_mouse.strobe = 1'b1;
		cur_mouse.dx = pad_pkg::mouse_delta_t'($random(seed));
		cur_mouse.dy = pad_pkg::mouse_delta_t'($random(seed));
		ax = -cur_mouse.dx;
		ay = cur_mouse.dy;
		push_row(1'b0, 1'b1, 4'h0);  // Captured but not yet latched
		clr_pulse();
		push_row(1'b0, 1'b1, ax[7:4]);
		push_row(1'b0, 1'b0, mouse_low_nibble(port0_pad(), 1'b1, 1'b0));
		clr_pulse();

		// Second report lands mid-packet
		cur_mouse.strobe = 1'b1;
		cur_mouse.dx = pad_pkg::mouse_delta_t'($random(seed));
		cur_mouse.dy = pad_pkg::mouse_delta_t'($random(seed));
		cur_mouse.rbtn = 1'b1;
		bx = -cur_mouse.dx;
		push_row(1'b0, 1'b1, ax[3:0]);
		clr_pulse();
		push_row(1'b0, 1'b1, ay[7:4]);
		clr_pulse();
		push_row(1'b0, 1'b1, ay[3:0]);
		clr_pulse();
		push_row(1'b0, 1'b1, bx[7:4]);
		push_row(1'b0, 1'b0, mouse_low_nibble(port0_pad(), 1'b1, 1'b1));
		clr_pulse();
		push_row(1'b0, 1'b1, bx[3:0]);
	endtask

	// ==============================
	// Run
	// ==============================

	task automatic wait_cycles(input int n, input string what);
		int cnt;
		int guard;

		cnt = 0;
		guard = 0;
		while (cnt < n && guard < n + 8) begin
			@(posedge clk_sys);
			cnt++;
			guard++;
		end
		if (cnt < n)
			note_timeout(what);
	endtask

	initial begin
		row_t r;
		int used;

		rst = 1'b1;
		ctrl = '0;
		cfg = '0;
		mouse = '0;
		for (int j = 0; j < `PAD_PORT_COUNT; j++)
			host_pads[j] = '0;

		build_table();

		wait_cycles(10, "reset hold");
		@(negedge clk_sys);
		check_nibble(4'h0, joy_in, -1);
		@(posedge clk_sys);
		rst <= 1'b0;

		for (int i = 0; i < table_q.size(); i++) begin
			r = table_q[i];
			used = 0;
			@(posedge clk_sys);
			ctrl  <= r.ctrl;
			cfg   <= r.cfg;
			mouse <= r.mouse;
			for (int j = 0; j < `PAD_PORT_COUNT; j++)
				host_pads[j] <= r.pads[j];
			if (r.mouse.strobe) begin
				@(posedge clk_sys);
				mouse.strobe <= 1'b0;  // Single cycle report
				used = 1;
			end
			wait_cycles(SETTLE_CYCLES - used, "row settle");
			@(negedge clk_sys);
			check_nibble(r.exp, joy_in, i);
		end

		$display("rows: %0d, errors: %0d, timeouts: %0d", table_q.size(), err_count,
			timeout_count);
		if (err_count == 0 && timeout_count == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* design/pad_port_top.sv */
/*
 * Controller port top level
 * Decode, mouse packet and multitap sequencer between the host pads
 * and the nibble the console reads
 */

`default_nettype none

`include "pad_params.svh"

module pad_port_top (
	input  wire                    clk_sys,
	input  wire                    rst,
	input  pad_pkg::pad_ctrl_t     ctrl,
	input  pad_pkg::pad_cfg_t      cfg,
	input  pad_pkg::host_pad_t     host_pads [`PAD_PORT_COUNT],
	input  pad_pkg::mouse_report_t mouse,
	output pad_pkg::nibble_t       joy_in
);

	pad_pkg::pad_event_t ev;
	pad_pkg::pad_word_t  pad_words [`PAD_PORT_COUNT];
	pad_pkg::nibble_t    mouse_nib;

	pad_decode i_pad_decode (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.ctrl      (ctrl),
		.cfg       (cfg),
		.host_pads (host_pads),
		.ev        (ev),
		.pad_words (pad_words)
	);

	mouse_packet i_mouse_packet (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.ev        (ev),
		.mouse     (mouse),
		.mouse_nib (mouse_nib)
	);

	// Also takes the result latch
	tap_sequencer i_tap_sequencer (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.ev        (ev),
		.cfg       (cfg),
		.pad_words (pad_words),
		.mouse     (mouse),
		.mouse_nib (mouse_nib),
		.joy_in    (joy_in)
	);

endmodule

`default_nettype wire

/* design/tap_sequencer.sv */
/*
 * Multitap sequencer
 * Steps the multitap port on sel, toggles the six-button half on clr,
 * picks the word for the current port and latches the nibble the console reads
 */

`default_nettype none

`include "pad_params.svh"

module tap_sequencer (
	input  wire                    clk_sys,
	input  wire                    rst,
	input  pad_pkg::pad_event_t    ev,
	input  pad_pkg::pad_cfg_t      cfg,
	input  pad_pkg::pad_word_t     pad_words [`PAD_PORT_COUNT],
	input  pad_pkg::mouse_report_t mouse,
	input  pad_pkg::nibble_t       mouse_nib,
	output pad_pkg::nibble_t       joy_in
);

	pad_pkg::port_idx_t port;
	logic               high_buttons;  // Second half of a six-button pad
	logic [7:0]         mouse_byte;
	pad_pkg::pad_word_t cur_word;
	pad_pkg::nibble_t   cur_nib;

	// ==============================
	// Word and nibble select
	// ==============================

	// Movement nibble on top, run and select plus mouse buttons below
	assign mouse_byte = {mouse_nib, pad_words[0][3:2], ~mouse.lbtn, ~mouse.rbtn};

	always_comb begin
		if (port >= pad_pkg::port_idx_t'(`PAD_PORT_COUNT)) begin
			cur_word = `PAD_IDLE_WORD;  // Nothing behind ports 5 to 7
		end else if (port == '0 && cfg.mouse_en) begin
			cur_word = {mouse_byte, mouse_byte};
		end else begin
			cur_word = pad_words[port];
		end
	end

	assign cur_nib = cur_word[{high_buttons, ev.sel, 2'b00} +: `PAD_NIBBLE_BITS];

	// ==============================
	// Port counter and latch
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			port         <= '0;
			high_buttons <= 1'b0;
			joy_in       <= '0;
		end else begin
			joy_in <= cur_nib;
			if (ev.clr) begin
				// Console holds clr high to restart the scan
				port   <= '0;
				joy_in <= '0;
				if (ev.clr_rise)
					high_buttons <= ~high_buttons & cfg.buttons6;
			end else if (ev.sel_rise && cfg.turbotap) begin
				port <= port + 3'd1;  // Wraps at 8
			end
		end
	end

endmodule

`default_nettype wire

/* design/mouse_packet.sv */
/*
 * Mouse packet builder
 * Holds the latest host mouse report and hands the console one movement
 * nibble per clr rise, x high first and y low last
 */

`default_nettype none

`include "pad_params.svh"

module mouse_packet (
	input  wire                    clk_sys,
	input  wire                    rst,
	input  pad_pkg::pad_event_t    ev,
	input  pad_pkg::mouse_report_t mouse,
	output pad_pkg::nibble_t       mouse_nib
);

	pad_pkg::mouse_delta_t pend_x;  // Waiting for the next packet
	pad_pkg::mouse_delta_t pend_y;
	pad_pkg::mouse_delta_t cur_x;   // Packet being read out
	pad_pkg::mouse_delta_t cur_y;
	logic [1:0] nib_cnt;
	logic [`PAD_MOUSE_TIMEOUT_BITS-1:0] idle_cnt;

	// ==============================
	// Idle timeout
	// ==============================

	// Console stops pulsing clr when it gives up on the mouse
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			idle_cnt <= '1;
		end else if (ev.clr) begin
			idle_cnt <= '0;
		end else if (~&idle_cnt) begin
			idle_cnt <= idle_cnt + 1'b1;
		end
	end

	// ==============================
	// Packet state
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			nib_cnt <= 2'd3;
			pend_x  <= '0;
			pend_y  <= '0;
			cur_x   <= '0;
			cur_y   <= '0;
		end else begin
			if (&idle_cnt)
				nib_cnt <= 2'd3;  // Resync, next clr rise starts a packet
			if (ev.clr_rise) begin
				nib_cnt <= nib_cnt + 2'd1;
				if (&nib_cnt) begin
					cur_x  <= pend_x;
					cur_y  <= pend_y;
					pend_x <= '0;
					pend_y <= '0;
				end
			end
			// Late report wins over the clear above
			if (mouse.strobe) begin
				pend_x <= -mouse.dx;  // Console x axis runs the other way
				pend_y <= mouse.dy;
			end
		end
	end

	always_comb begin
		case (nib_cnt)
			2'd0: mouse_nib = cur_x[7:4];
			2'd1: mouse_nib = cur_x[3:0];
			2'd2: mouse_nib = cur_y[7:4];
			default: mouse_nib = cur_y[3:0];
		endcase
	end

endmodule

`default_nettype wire

/* design/pad_decode.sv */
/*
 * Pad decode
 * Registers the console control lines and flags their rising edges,
 * then turns each host gamepad word into an active-low console pad word
 */

`default_nettype none

`include "pad_params.svh"

module pad_decode (
	input  wire                      clk_sys,
	input  wire                      rst,
	input  pad_pkg::pad_ctrl_t       ctrl,
	input  pad_pkg::pad_cfg_t        cfg,
	input  pad_pkg::host_pad_t       host_pads [`PAD_PORT_COUNT],
	output pad_pkg::pad_event_t      ev,
	output pad_pkg::pad_word_t       pad_words [`PAD_PORT_COUNT]
);

	// ==============================
	// Control lines
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			ev <= '0;
		end else begin
			ev.clr      <= ctrl.clr;
			ev.sel      <= ctrl.sel;
			ev.clr_rise <= ctrl.clr & ~ev.clr;  // ev.clr holds last cycle's line
			ev.sel_rise <= ctrl.sel & ~ev.sel;
		end
	end

	// ==============================
	// Pad words
	// ==============================

	// Host order is right, left, down, up, I, II, select, run, III..VI
	// Console nibbles are buttons, directions, extra buttons, zero
	function automatic pad_pkg::pad_word_t remap_pad(input pad_pkg::host_pad_t h);
		pad_pkg::nibble_t dirs;

		dirs = {h[1], h[2], h[0], h[3]};  // Left, down, right, up
		remap_pad = {4'h0, ~h[11:8], ~dirs, ~h[7:4]};
	endfunction

	pad_pkg::host_pad_t src_pads [`PAD_PORT_COUNT];

	always_comb begin
		for (int i = 0; i < `PAD_PORT_COUNT; i++) begin
			src_pads[i] = host_pads[i];
		end
		if (cfg.swap) begin
			src_pads[0] = host_pads[1];
			src_pads[1] = host_pads[0];
		end
	end

	always_ff @(posedge clk_sys) begin
		for (int i = 0; i < `PAD_PORT_COUNT; i++) begin
			pad_words[i] <= remap_pad(src_pads[i]);
		end
	end

endmodule

`default_nettype wire

/* design/pad_pkg.sv */
/*
 * Controller port types
 * Vector widths and packed bundles shared by the port logic
 */

`default_nettype none

`include "pad_params.svh"

package pad_pkg;

	typedef logic [`PAD_NIBBLE_BITS-1:0] nibble_t;      // One console read
	typedef logic [4*`PAD_NIBBLE_BITS-1:0] pad_word_t;  // Four nibbles, active low
	typedef logic [`PAD_HOST_BITS-1:0] host_pad_t;      // Host gamepad buttons
	typedef logic [2:0] port_idx_t;                     // Multitap port number
	typedef logic signed [7:0] mouse_delta_t;           // One axis step

	// Console output lines, clr on bit 1 and sel on bit 0
	typedef struct packed {
		logic clr;
		logic sel;
	} pad_ctrl_t;

	// Static options from the host menu
	typedef struct packed {
		logic swap;      // Trade host ports 0 and 1
		logic turbotap;  // Five port multitap
		logic buttons6;  // Six button pads
		logic mouse_en;  // Mouse on port 0
	} pad_cfg_t;

	typedef struct packed {
		logic         strobe;  // Single cycle, report valid
		mouse_delta_t dx;
		mouse_delta_t dy;
		logic         lbtn;
		logic         rbtn;
	} mouse_report_t;

	// Registered control lines with their rising edges
	typedef struct packed {
		logic clr;
		logic sel;
		logic clr_rise;
		logic sel_rise;
	} pad_event_t;

endpackage

`default_nettype wire

/* design/pad_params.svh */
/*
 * Controller port parameters
 * Port count, host and console widths, mouse idle timeout and the
 * word seen on a multitap port with nothing plugged in
 */

`ifndef PAD_PARAMS_SVH
`define PAD_PARAMS_SVH

// Multitap ports behind the console connector
`define PAD_PORT_COUNT 5

// Host gamepad word, only the low bits carry buttons
`define PAD_HOST_BITS 12

// Console reads one nibble at a time
`define PAD_NIBBLE_BITS 4

// Idle counter width, saturation resets the mouse packet
`define PAD_MOUSE_TIMEOUT_BITS 15

// Empty multitap port
`define PAD_IDLE_WORD 16'h0FFF

`endif
